//--- list.f
+incdir+.
spi_pkg.sv
bus_pkg.sv
spi_byte.sv
pi_com.sv
bus_port.sv
pet_ram.sv
pi_bridge_top.sv
tb_pi_bridge.sv

//--- Makefile
TOP := tb_pi_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- tb_pi_bridge.sv
`timescale 1ns/10ps
`default_nettype none
`include "pi_bridge_defs.svh"

module tb_pi_bridge;

    localparam int         DRV_DLY      = 10;
    localparam int         HALF_SCLK    = 4;     // sys_clk cycles per sclk phase
    localparam int         ITERS        = 8;
    localparam int         DONE_TIMEOUT = 40;
    localparam int         TRANSACTIONS = (ITERS + 1) * 4 + 10;
    localparam int         TRANS_CYCLES = 400;   // longest transaction plus margin
    localparam logic [2:0] LEN_NEXT     = 3'd1;
    localparam logic [2:0] LEN_READ     = 3'd3;
    localparam logic [2:0] LEN_WRITE    = 3'd4;

    logic sys_clk;
    logic reset;
    logic spi_sclk;
    logic spi_cs_n;
    logic spi_mosi;
    wire  spi_miso;
    wire  busy;
    wire  done;

    logic [`PI_DATA_W-1:0] ref_mem [2 ** `PI_ADDR_W];
    logic [31:0]           lcg_state;
    logic                  after_reset;   // window right after reset release
    logic                  read_seen;     // first read has started
    logic                  access_armed;  // a memory access is expected
    logic                  read_chk;
    logic [7:0]            read_got;
    logic [7:0]            read_exp;
    int                    check_errors;
    int                    timeouts;

    pi_bridge_top u_dut (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // len, reserved, set_addr, rw_b, a16
    function automatic logic [7:0] cmd_byte(input logic [2:0] len, input logic rw_b,
                                            input logic bank);
        return {len, 2'b00, 1'b0, rw_b, bank};
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge sys_clk);
            #DRV_DLY;
        end
    endtask

    // mode 0 with msb first and miso taken at the rising edge
    task automatic shift_byte(input logic [7:0] mosi_b, output logic [7:0] miso_b);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = mosi_b[i];
            step(HALF_SCLK);
            spi_sclk  = 1'b1;
            miso_b[i] = spi_miso;
            step(HALF_SCLK);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic cs_select();
        spi_cs_n = 1'b0;
        step(HALF_SCLK);
    endtask

    task automatic cs_release();
        step(HALF_SCLK);
        spi_cs_n = 1'b1;
        step(8);              // FSM sees chip select high and clears done
        access_armed = 1'b0;
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        while (!done && cnt < DONE_TIMEOUT) begin
            step(1);
            cnt++;
        end
        if (!done) begin
            timeouts++;
            $display("timeout at %0t: done never rose after the memory access", $time);
        end
        step(2);
    endtask

    task automatic mem_write(input logic [`PI_ADDR_W-1:0] addr, input logic [7:0] data);
        logic [7:0] dummy;
        cs_select();
        shift_byte(cmd_byte(LEN_WRITE, 1'b0, addr[`PI_ADDR_W-1]), dummy);
        shift_byte(data, dummy);
        shift_byte(addr[15:8], dummy);
        shift_byte(addr[7:0], dummy);
        access_armed = 1'b1;
        wait_done();
        cs_release();
        ref_mem[addr] = data;
    endtask

    task automatic mem_read(input logic [`PI_ADDR_W-1:0] addr, output logic [7:0] got);
        logic [7:0] dummy;
        read_seen = 1'b1;
        cs_select();
        shift_byte(cmd_byte(LEN_READ, 1'b1, addr[`PI_ADDR_W-1]), dummy);
        shift_byte(addr[15:8], dummy);
        shift_byte(addr[7:0], dummy);
        access_armed = 1'b1;
        wait_done();
        shift_byte(8'h00, got);   // data comes back in the byte after done
        cs_release();
    endtask

    task automatic read_next(output logic [7:0] got);
        logic [7:0] dummy;
        read_seen    = 1'b1;
        cs_select();
        shift_byte(cmd_byte(LEN_NEXT, 1'b1, 1'b0), dummy);
        access_armed = 1'b1;
        wait_done();
        shift_byte(8'h00, got);
        cs_release();
    endtask

    task automatic check_read(input logic [7:0] got, input logic [7:0] expected);
        read_got = got;
        read_exp = expected;
        read_chk = 1'b1;
        step(1);
        read_chk = 1'b0;
    endtask

    initial begin
        logic [`PI_ADDR_W-1:0] addr;
        logic [`PI_ADDR_W-1:0] addr_nx;
        logic [7:0]            d0;
        logic [7:0]            d1;
        logic [7:0]            got;
        reset        = 1'b1;
        spi_sclk     = 1'b0;
        spi_cs_n     = 1'b1;
        spi_mosi     = 1'b0;
        after_reset  = 1'b0;
        read_seen    = 1'b0;
        access_armed = 1'b0;
        read_chk     = 1'b0;
        read_got     = '0;
        read_exp     = '0;
        check_errors = 0;
        timeouts     = 0;
        lcg_state    = 32'he3d78f29;
        addr         = '0;
        repeat (3) @(posedge sys_clk);
        #DRV_DLY;
        reset       = 1'b0;
        after_reset = 1'b1;
        step(10);
        after_reset = 1'b0;

        // write two neighbours, read one back, then the next address
        for (int n = 0; n < ITERS; n++) begin
            lcg_state = lcg_next(lcg_state);
            addr      = lcg_state[31:15];
            lcg_state = lcg_next(lcg_state);
            d0        = lcg_state[31:24];
            d1        = lcg_state[23:16];
            addr_nx   = {addr[`PI_ADDR_W-1], addr[15:0] + 16'd1};   // wraps in the bank
            mem_write(addr, d0);
            mem_write(addr_nx, d1);
            mem_read(addr, got);
            check_read(got, ref_mem[addr]);
            read_next(got);
            check_read(got, ref_mem[addr_nx]);
        end

        // next address at the top of bank 1 stays in bank 1
        addr    = {1'b1, 16'hffff};
        addr_nx = {1'b1, 16'h0000};
        mem_write(addr, d0);
        mem_write(addr_nx, d1);
        mem_read(addr, got);
        check_read(got, ref_mem[addr]);
        read_next(got);
        check_read(got, ref_mem[addr_nx]);

        // length codes without a meaning
        for (int c = 0; c < 8; c++) begin
            if (c[2:0] != LEN_NEXT && c[2:0] != LEN_READ && c[2:0] != LEN_WRITE) begin
                cs_select();
                shift_byte(cmd_byte(c[2:0], 1'b0, addr[`PI_ADDR_W-1]), got);
                shift_byte(8'h00, got);
                cs_release();
            end
        end
        mem_read(addr, got);
        check_read(got, ref_mem[addr]);

        // writes cut short by chip select
        d0 = ~ref_mem[addr];
        cs_select();
        shift_byte(cmd_byte(LEN_WRITE, 1'b0, addr[`PI_ADDR_W-1]), got);
        shift_byte(d0, got);
        shift_byte(addr[15:8], got);
        cs_release();
        cs_select();
        shift_byte(cmd_byte(LEN_WRITE, 1'b0, addr[`PI_ADDR_W-1]), got);
        shift_byte(d0, got);
        cs_release();
        mem_read(addr, got);
        check_read(got, ref_mem[addr]);

        $display("checks failed: %0d, done timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TRANSACTIONS * TRANS_CYCLES) @(posedge sys_clk);
        $display("watchdog expired, the run took longer than %0d transactions", TRANSACTIONS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    read_data_ok: assert property (@(posedge sys_clk) disable iff (reset)
        read_chk |-> (read_got == read_exp))
        else begin
            check_errors = check_errors + 1;
            $display("MISMATCH t=%0t signal=spi_miso expected=%02h actual=%02h",
                     $time, read_exp, read_got);
        end

    busy_idle_after_reset: assert property (@(posedge sys_clk) disable iff (reset)
        after_reset |-> !busy)
        else begin
            check_errors = check_errors + 1;
            $display("MISMATCH t=%0t signal=busy expected=0 actual=%b", $time, busy);
        end

    done_idle_after_reset: assert property (@(posedge sys_clk) disable iff (reset)
        after_reset |-> !done)
        else begin
            check_errors = check_errors + 1;
            $display("MISMATCH t=%0t signal=done expected=0 actual=%b", $time, done);
        end

    miso_zero_before_read: assert property (@(posedge sys_clk) disable iff (reset)
        !read_seen |-> !spi_miso)
        else begin
            check_errors = check_errors + 1;
            $display("MISMATCH t=%0t signal=spi_miso expected=0 actual=%b", $time, spi_miso);
        end

    busy_only_with_access: assert property (@(posedge sys_clk) disable iff (reset)
        busy |-> access_armed)
        else begin
            check_errors = check_errors + 1;
            $display("busy high at %0t although no memory access was requested", $time);
        end

    done_only_with_access: assert property (@(posedge sys_clk) disable iff (reset)
        done |-> access_armed)
        else begin
            check_errors = check_errors + 1;
            $display("done high at %0t although no memory access was requested", $time);
        end

    busy_ends_with_done: assert property (@(posedge sys_clk) disable iff (reset)
        $fell(busy) |-> $rose(done))
        else begin
            check_errors = check_errors + 1;
            $display("busy fell at %0t without done rising in the same cycle", $time);
        end

    done_starts_at_busy_end: assert property (@(posedge sys_clk) disable iff (reset)
        $rose(done) |-> $fell(busy))
        else begin
            check_errors = check_errors + 1;
            $display("done rose at %0t while busy did not fall", $time);
        end

    done_held: assert property (@(posedge sys_clk) disable iff (reset)
        (done && !spi_cs_n) |=> done)
        else begin
            check_errors = check_errors + 1;
            $display("done dropped at %0t while chip select was still low", $time);
        end

endmodule

`default_nettype wire

//--- pi_bridge_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "pi_bridge_defs.svh"

module pi_bridge_top (
    input  wire  sys_clk,
    input  wire  reset,
    input  wire  spi_sclk,
    input  wire  spi_cs_n,
    input  wire  spi_mosi,
    output logic spi_miso,
    output logic busy,
    output logic done
);

    logic [7:0]            tx_data;
    logic [7:0]            rx;
    logic                  rx_valid;
    bus_pkg::bus_req_t     req;
    logic                  req_valid;
    bus_pkg::bus_rsp_t     rsp;
    logic                  port_done;
    logic [`PI_ADDR_W-1:0] mem_addr;
    logic [`PI_DATA_W-1:0] mem_wdata;
    logic                  mem_we;
    logic [`PI_DATA_W-1:0] mem_rdata;

    spi_byte u_spi_byte (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .tx_data  (tx_data),
        .rx       (rx),
        .rx_valid (rx_valid)
    );

    pi_com u_pi_com (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .spi_cs_n  (spi_cs_n),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .tx_data   (tx_data),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .done_in   (port_done),
        .busy      (busy),
        .done      (done)
    );

    bus_port u_bus_port (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .done      (port_done),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    pet_ram u_pet_ram (
        .sys_clk (sys_clk),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .we      (mem_we),
        .rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

//--- pet_ram.sv
`timescale 1ns/10ps
`default_nettype none
`include "pi_bridge_defs.svh"

module pet_ram (
    input  wire                   sys_clk,
    input  wire  [`PI_ADDR_W-1:0] addr,
    input  wire  [`PI_DATA_W-1:0] wdata,
    input  wire                   we,
    output logic [`PI_DATA_W-1:0] rdata
);

    localparam int DEPTH = 2 ** `PI_ADDR_W;

    logic [`PI_DATA_W-1:0] mem [DEPTH];

    // read returns the old contents on a write cycle
    always_ff @(posedge sys_clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- bus_port.sv
`timescale 1ns/10ps
`default_nettype none
`include "pi_bridge_defs.svh"

module bus_port (
    input  wire                         sys_clk,
    input  wire                         reset,
    input  bus_pkg::bus_req_t           req,
    input  wire                         req_valid,
    output bus_pkg::bus_rsp_t           rsp,
    output logic                        done,
    output logic [`PI_ADDR_W-1:0]       mem_addr,
    output logic [`PI_DATA_W-1:0]       mem_wdata,
    output logic                        mem_we,
    input  wire  [`PI_DATA_W-1:0]       mem_rdata
);

    localparam int CNT_W = $clog2(`PI_WAIT_STATES + 1);

    bus_pkg::bus_req_t req_q;
    logic              active;     // access in progress
    logic [CNT_W-1:0]  wait_cnt;
    logic              last;

    assign mem_addr  = req_q.addr;   // held for the whole access
    assign mem_wdata = req_q.wdata;
    assign last      = (wait_cnt == CNT_W'(`PI_WAIT_STATES - 1));

    always_ff @(posedge sys_clk) begin
        if (req_valid) begin
            req_q <= req;
        end
    end

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            wait_cnt <= '0;
            mem_we   <= 1'b0;
            done     <= 1'b0;
        end else begin
            done   <= 1'b0;
            mem_we <= 1'b0;
            if (req_valid) begin
                active   <= 1'b1;
                wait_cnt <= '0;
                mem_we   <= req.we;    // single write pulse on the first cycle
            end else if (active) begin
                wait_cnt <= wait_cnt + CNT_W'(1);
                if (last) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // ram output has settled by the last wait cycle
    always_ff @(posedge sys_clk) begin
        if (active && last) begin
            rsp.rdata <= mem_rdata;
        end
    end

    a_no_req_when_active: assert property (@(posedge sys_clk) disable iff (reset)
        req_valid |-> !active)
        else $error("request arrived during a memory access");

endmodule

`default_nettype wire

//--- pi_com.sv
`timescale 1ns/10ps
`default_nettype none
`include "pi_bridge_defs.svh"

module pi_com (
    input  wire               sys_clk,
    input  wire               reset,
    input  wire               spi_cs_n,
    input  wire         [7:0] rx,
    input  wire               rx_valid,
    output logic        [7:0] tx_data,
    output bus_pkg::bus_req_t req,
    output logic              req_valid,
    input  bus_pkg::bus_rsp_t rsp,
    input  wire               done_in,
    output logic              busy,
    output logic              done
);

    typedef enum logic [2:0] {
        READ_CMD,
        READ_DATA_ARG,
        READ_ADDR_HI_ARG,
        READ_ADDR_LO_ARG,
        XFER,
        DONE
    } state_t;

    state_t                     state;
    spi_pkg::spi_cmd_t          cmd;
    logic [`PI_SYNC_STAGES-1:0] cs_sync;
    logic                       cs_s;
    logic [`PI_ADDR_W-1:0]      addr_q;
    logic [`PI_DATA_W-1:0]      wdata_q;
    logic                       rw_b;
    logic                       byte_in;   // byte accepted this cycle

    assign cmd     = spi_pkg::spi_cmd_t'(rx);
    assign cs_s    = cs_sync[`PI_SYNC_STAGES-1];
    assign byte_in = rx_valid && !cs_s;

    assign req.addr  = addr_q;
    assign req.wdata = wdata_q;
    assign req.we    = ~rw_b;

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            cs_sync <= '1;
        end else begin
            cs_sync <= {cs_sync[`PI_SYNC_STAGES-2:0], spi_cs_n};
        end
    end

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            state     <= READ_CMD;
            rw_b      <= 1'b1;
            req_valid <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            tx_data   <= '0;
        end else if (cs_s) begin
            // end of transaction, drop whatever was in progress
            state     <= READ_CMD;
            req_valid <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                READ_CMD: begin
                    if (rx_valid) begin
                        case (cmd.len)
                            spi_pkg::CMD_LEN_NEXT: begin
                                rw_b      <= 1'b1;
                                req_valid <= 1'b1;
                                busy      <= 1'b1;
                                state     <= XFER;
                            end
                            spi_pkg::CMD_LEN_READ: begin
                                rw_b  <= 1'b1;
                                state <= READ_ADDR_HI_ARG;
                            end
                            spi_pkg::CMD_LEN_WRITE: begin
                                rw_b  <= 1'b0;
                                state <= READ_DATA_ARG;
                            end
                            default: state <= READ_CMD;
                        endcase
                    end
                end
                READ_DATA_ARG: if (rx_valid) state <= READ_ADDR_HI_ARG;
                READ_ADDR_HI_ARG: if (rx_valid) state <= READ_ADDR_LO_ARG;
                READ_ADDR_LO_ARG: begin
                    if (rx_valid) begin
                        req_valid <= 1'b1;  // address complete, start access
                        busy      <= 1'b1;
                        state     <= XFER;
                    end
                end
                XFER: begin
                    if (done_in) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= DONE;
                        if (rw_b) begin
                            tx_data <= rsp.rdata;   // shifted out in the next byte
                        end
                    end
                end
                default: state <= DONE;  // hold until chip select rises
            endcase
        end
    end

    // address and data registers, loaded from the argument bytes
    always_ff @(posedge sys_clk) begin
        if (byte_in) begin
            case (state)
                READ_CMD: begin
                    if (cmd.len == spi_pkg::CMD_LEN_NEXT) begin
                        addr_q <= {addr_q[`PI_ADDR_W-1], addr_q[`PI_ADDR_W-2:0] + 1'b1};
                    end else if (cmd.len == spi_pkg::CMD_LEN_READ ||
                                 cmd.len == spi_pkg::CMD_LEN_WRITE) begin
                        addr_q[`PI_ADDR_W-1] <= cmd.a16;
                    end
                end
                READ_DATA_ARG:    wdata_q      <= rx;
                READ_ADDR_HI_ARG: addr_q[15:8] <= rx;
                READ_ADDR_LO_ARG: addr_q[7:0]  <= rx;
                default: ;
            endcase
        end
    end

    a_req_one_cycle: assert property (@(posedge sys_clk) disable iff (reset)
        req_valid |=> !req_valid)
        else $error("req_valid held for more than one cycle");

    // host has to wait for the access before the next byte
    a_no_rx_in_xfer: assert property (@(posedge sys_clk) disable iff (reset)
        (state == XFER) |-> !rx_valid)
        else $error("byte received while a memory access is pending");

endmodule

`default_nettype wire

//--- spi_byte.sv
`timescale 1ns/10ps
`default_nettype none
`include "pi_bridge_defs.svh"

module spi_byte (
    input  wire        sys_clk,
    input  wire        reset,
    input  wire        spi_sclk,
    input  wire        spi_cs_n,
    input  wire        spi_mosi,
    output logic       spi_miso,
    input  wire  [7:0] tx_data,
    output logic [7:0] rx,
    output logic       rx_valid
);

    logic [`PI_SYNC_STAGES-1:0] sclk_sync;
    logic [`PI_SYNC_STAGES-1:0] cs_sync;
    logic [`PI_SYNC_STAGES-1:0] mosi_sync;
    logic       sclk_s;
    logic       sclk_d;     // previous synced sclk
    logic       cs_s;
    logic       mosi_s;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       first_fall; // falling edge that opens the next byte
    logic [2:0] bit_cnt;
    logic [7:0] tx_sr;
    logic       tx_follow;  // tx_sr tracks tx_data until the byte starts

    assign sclk_s     = sclk_sync[`PI_SYNC_STAGES-1];
    assign cs_s       = cs_sync[`PI_SYNC_STAGES-1];
    assign mosi_s     = mosi_sync[`PI_SYNC_STAGES-1];
    assign sclk_rise  = !cs_s && sclk_s && !sclk_d;
    assign sclk_fall  = !cs_s && !sclk_s && sclk_d;
    assign first_fall = sclk_fall && (bit_cnt == 3'd0);
    assign spi_miso   = tx_sr[7];

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            sclk_sync <= '0;
            cs_sync   <= '1;    // deselected
            sclk_d    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[`PI_SYNC_STAGES-2:0], spi_sclk};
            cs_sync   <= {cs_sync[`PI_SYNC_STAGES-2:0], spi_cs_n};
            sclk_d    <= sclk_s;
        end
    end

    // mosi runs through the same depth so it lines up with sclk
    always_ff @(posedge sys_clk) begin
        mosi_sync <= {mosi_sync[`PI_SYNC_STAGES-2:0], spi_mosi};
    end

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (cs_s) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;
                rx_valid <= (bit_cnt == 3'd7);   // 8th bit just came in
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sclk_rise) begin
            rx <= {rx[6:0], mosi_s};
        end
    end

    // mode 0: msb is on the line before the first rising edge
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            tx_sr     <= '0;
            tx_follow <= 1'b0;
        end else begin
            if (cs_s || first_fall) begin
                tx_follow <= 1'b1;
            end else if (sclk_rise) begin
                tx_follow <= 1'b0;
            end

            if (cs_s || tx_follow || first_fall) begin
                tx_sr <= tx_data;
            end else if (sclk_fall) begin
                tx_sr <= {tx_sr[6:0], 1'b0};
            end
        end
    end

    a_no_rx_deselected: assert property (@(posedge sys_clk) disable iff (reset)
        cs_s |-> !rx_valid)
        else $error("rx_valid while chip select is high");

endmodule

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none
`include "pi_bridge_defs.svh"

package bus_pkg;

    // one access from the control FSM to the memory port
    typedef struct packed {
        logic [`PI_ADDR_W-1:0] addr;
        logic [`PI_DATA_W-1:0] wdata;
        logic                  we;     // 1 = write, 0 = read
    } bus_req_t;

    // answer from the memory port, valid with done
    typedef struct packed {
        logic [`PI_DATA_W-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

    // command byte, MSB first on the wire
    typedef struct packed {
        logic [2:0] len;       // selects the command
        logic [1:0] reserved;
        logic       set_addr;  // not supported
        logic       rw_b;
        logic       a16;       // memory bank
    } spi_cmd_t;

    // length codes that carry a meaning, the rest are dropped
    localparam logic [2:0] CMD_LEN_NEXT  = 3'd1;  // read at held address + 1
    localparam logic [2:0] CMD_LEN_READ  = 3'd3;  // cmd, addr hi, addr lo
    localparam logic [2:0] CMD_LEN_WRITE = 3'd4;  // cmd, data, addr hi, addr lo

endpackage

`default_nettype wire

//--- pi_bridge_defs.svh
`ifndef PI_BRIDGE_DEFS_SVH
`define PI_BRIDGE_DEFS_SVH

// memory geometry, 128 KiB in two 64 KiB banks
`define PI_ADDR_W 17
`define PI_DATA_W 8

// extra cycles the memory port holds the address before done
`define PI_WAIT_STATES 2

// flops between the SPI pins and the sys_clk logic
`define PI_SYNC_STAGES 2

`endif
